// ==== rtl/controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module controller
	import ctrl_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire opcode_t opcode,
	input wire flags_t flags,
	output ctrl_word_t ctrl_word
);

	instr_class_t iclass;
	reg_sel_t dst_sel;
	reg_sel_t src_sel;
	logic dst_is_acc;
	logic src_is_acc;
	reg_sel_t pair_hi_sel;
	alu_op_t alu_op;
	reg_ext_t ext_dir;
	logic cond_met;
	stage_t stage;
	ctrl_word_t exec_word;
	logic last;

	instr_decoder u_decoder (
		.opcode(opcode),
		.flags(flags),
		.iclass(iclass),
		.dst_sel(dst_sel),
		.src_sel(src_sel),
		.dst_is_acc(dst_is_acc),
		.src_is_acc(src_is_acc),
		.pair_hi_sel(pair_hi_sel),
		.alu_op(alu_op),
		.ext_dir(ext_dir),
		.cond_met(cond_met)
	);

	stage_sequencer u_sequencer (
		.clk(clk),
		.rst(rst),
		.iclass(iclass),
		.exec_word(exec_word),
		.last(last),
		.stage(stage),
		.ctrl_word(ctrl_word)
	);

	exec_microcode u_microcode (
		.stage(stage),
		.iclass(iclass),
		.dst_sel(dst_sel),
		.src_sel(src_sel),
		.dst_is_acc(dst_is_acc),
		.src_is_acc(src_is_acc),
		.pair_hi_sel(pair_hi_sel),
		.alu_op(alu_op),
		.ext_dir(ext_dir),
		.cond_met(cond_met),
		.exec_word(exec_word),
		.last(last)
	);

endmodule

`default_nettype wire

// ==== rtl/ctrl_consts.svh ====
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

// Control word layout
`define CW_WIDTH           30
`define CW_IR_WE           0
`define CW_MEM_OE          1
`define CW_MEM_MAR_WE      2
`define CW_MEM_WE          3
`define CW_REG_WE          4
`define CW_REG_OE          5
`define CW_REG_EXT_LO      6
`define CW_REG_EXT_HI      7
`define CW_REG_WR_SEL_LO   8
`define CW_REG_WR_SEL_HI   12
`define CW_REG_RD_SEL_LO   13
`define CW_REG_RD_SEL_HI   17
`define CW_ALU_OE          18
`define CW_ALU_OP_LO       19
`define CW_ALU_OP_HI       23
`define CW_ALU_TMP_WE      24
`define CW_ALU_A_RESTORE   25
`define CW_ALU_A_STORE     26
`define CW_ALU_A_WE        27
`define CW_ALU_CS          28
`define CW_HLT             29

// Register file selects, bit 4 marks a 16-bit pair
`define REG_BC             5'b10000
`define REG_DE             5'b10010
`define REG_HL             5'b10100
`define REG_WZ             5'b10110
`define REG_PC             5'b11000
`define REG_SP             5'b11010
`define REG_B              5'b00000
`define REG_C              5'b00001
`define REG_D              5'b00010
`define REG_E              5'b00011
`define REG_H              5'b00100
`define REG_L              5'b00101
`define REG_W              5'b00110
`define REG_Z              5'b00111

// Register file extension operations
`define REG_EXT_NONE       2'b00
`define REG_INC            2'b01
`define REG_DEC            2'b10
`define REG_INC2           2'b11

// ALU operations
`define ALU_OP_SET0        5'd0
`define ALU_OP_SET1        5'd8
`define ALU_OP_INC         5'd16
`define ALU_OP_DEC         5'd17

// First execute stage
`define FETCH_STAGES       4'd3

`endif

// ==== rtl/ctrl_pkg.sv ====
`default_nettype none

`include "ctrl_consts.svh"

package ctrl_pkg;

	typedef logic [7:0] opcode_t;
	// Condition flags live in bits 3:0
	typedef logic [7:0] flags_t;
	typedef logic [3:0] stage_t;
	typedef logic [4:0] reg_sel_t;
	typedef logic [1:0] reg_ext_t;
	typedef logic [4:0] alu_op_t;
	typedef logic [`CW_WIDTH-1:0] ctrl_word_t;

	typedef enum logic [3:0] {
		IC_NOP,
		IC_HLT,
		IC_MOV_RR,
		IC_MOV_RM,
		IC_MOV_MR,
		IC_MVI_R,
		IC_MVI_M,
		IC_INR_R,
		IC_INR_M,
		IC_INX,
		IC_ALU_R,
		IC_ALU_M,
		IC_ALU_A,
		IC_LXI,
		IC_JMP,
		IC_JCOND
	} instr_class_t;

	typedef enum logic {
		SEQ_RUN,
		SEQ_HALT
	} seq_state_t;

endpackage

`default_nettype wire

// ==== rtl/exec_microcode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_consts.svh"

module exec_microcode
	import ctrl_pkg::*;
(
	input wire stage_t stage,
	input wire instr_class_t iclass,
	input wire reg_sel_t dst_sel,
	input wire reg_sel_t src_sel,
	input wire dst_is_acc,
	input wire src_is_acc,
	input wire reg_sel_t pair_hi_sel,
	input wire alu_op_t alu_op,
	input wire reg_ext_t ext_dir,
	input wire cond_met,
	output ctrl_word_t exec_word,
	output logic last
);

	function automatic ctrl_word_t bit_word(input int pos);
		ctrl_word_t w;
		w = '0;
		w[pos] = 1'b1;
		return w;
	endfunction

	function automatic ctrl_word_t rd_word(input reg_sel_t sel);
		ctrl_word_t w;
		w = bit_word(`CW_REG_OE);
		w[`CW_REG_RD_SEL_HI:`CW_REG_RD_SEL_LO] = sel;
		return w;
	endfunction

	function automatic ctrl_word_t wr_word(input reg_sel_t sel);
		ctrl_word_t w;
		w = bit_word(`CW_REG_WE);
		w[`CW_REG_WR_SEL_HI:`CW_REG_WR_SEL_LO] = sel;
		return w;
	endfunction

	// Increment/decrement in place, no register write
	function automatic ctrl_word_t ext_word(input reg_sel_t sel, input reg_ext_t ext);
		ctrl_word_t w;
		w = '0;
		w[`CW_REG_WR_SEL_HI:`CW_REG_WR_SEL_LO] = sel;
		w[`CW_REG_EXT_HI:`CW_REG_EXT_LO] = ext;
		return w;
	endfunction

	function automatic ctrl_word_t mar_word(input reg_sel_t sel);
		return rd_word(sel) | bit_word(`CW_MEM_MAR_WE);
	endfunction

	function automatic ctrl_word_t alu_word(input alu_op_t op);
		ctrl_word_t w;
		w = bit_word(`CW_ALU_CS);
		w[`CW_ALU_OP_HI:`CW_ALU_OP_LO] = op;
		return w;
	endfunction

	stage_t step;
	ctrl_word_t src_word;
	ctrl_word_t dst_word;

	assign step = stage - `FETCH_STAGES;

	// Accumulator lives in the ALU, not in the register file
	assign src_word = src_is_acc ? bit_word(`CW_ALU_OE) : rd_word(src_sel);
	assign dst_word = dst_is_acc ? bit_word(`CW_ALU_A_WE) : wr_word(dst_sel);

	always_comb begin
		exec_word = '0;
		last = 1'b0;
		case (iclass)
			IC_HLT: begin
				exec_word = bit_word(`CW_HLT);
			end
			IC_MOV_RR: begin
				exec_word = src_word | dst_word;
				last = 1'b1;
			end
			IC_MOV_RM, IC_MOV_MR: begin
				if (step == 4'd0) begin
					exec_word = mar_word(`REG_HL);
				end else if (iclass == IC_MOV_RM) begin
					exec_word = bit_word(`CW_MEM_OE) | dst_word;
					last = 1'b1;
				end else begin
					exec_word = src_word | bit_word(`CW_MEM_WE);
					last = 1'b1;
				end
			end
			IC_MVI_R: begin
				case (step)
					4'd0: exec_word = mar_word(`REG_PC);
					4'd1: exec_word = bit_word(`CW_MEM_OE) | dst_word;
					default: begin
						exec_word = ext_word(`REG_PC, `REG_INC);
						last = 1'b1;
					end
				endcase
			end
			IC_MVI_M: begin
				case (step)
					4'd0: exec_word = mar_word(`REG_PC);
					4'd1: exec_word = bit_word(`CW_MEM_OE) | wr_word(`REG_W);
					4'd2: exec_word = mar_word(`REG_HL);
					4'd3: exec_word = rd_word(`REG_W) | bit_word(`CW_MEM_WE);
					default: begin
						exec_word = ext_word(`REG_PC, `REG_INC);
						last = 1'b1;
					end
				endcase
			end
			IC_INR_R: begin
				if (dst_is_acc) begin
					exec_word = alu_word(alu_op);
					last = 1'b1;
				end else begin
					case (step)
						4'd0: exec_word = rd_word(dst_sel) | bit_word(`CW_ALU_A_STORE)
							| bit_word(`CW_ALU_A_WE);
						4'd1: exec_word = alu_word(alu_op);
						default: begin
							exec_word = bit_word(`CW_ALU_OE) | bit_word(`CW_ALU_A_RESTORE)
								| wr_word(dst_sel);
							last = 1'b1;
						end
					endcase
				end
			end
			IC_INR_M: begin
				case (step)
					4'd0: exec_word = mar_word(`REG_HL);
					4'd1: exec_word = bit_word(`CW_MEM_OE) | bit_word(`CW_ALU_A_STORE)
						| bit_word(`CW_ALU_A_WE);
					4'd2: exec_word = alu_word(alu_op);
					default: begin
						exec_word = bit_word(`CW_ALU_OE) | bit_word(`CW_ALU_A_RESTORE)
							| bit_word(`CW_MEM_WE);
						last = 1'b1;
					end
				endcase
			end
			IC_INX: begin
				exec_word = ext_word(pair_hi_sel, ext_dir);
				last = 1'b1;
			end
			IC_ALU_R: begin
				if (src_is_acc || step != 4'd0) begin
					exec_word = alu_word(alu_op);
					last = 1'b1;
				end
				if (step == 4'd0) begin
					exec_word = exec_word | src_word | bit_word(`CW_ALU_TMP_WE);
				end
			end
			IC_ALU_M: begin
				case (step)
					4'd0: exec_word = mar_word(`REG_HL);
					4'd1: exec_word = bit_word(`CW_MEM_OE) | bit_word(`CW_ALU_TMP_WE);
					default: begin
						exec_word = alu_word(alu_op);
						last = 1'b1;
					end
				endcase
			end
			IC_ALU_A: begin
				exec_word = alu_word(alu_op);
				last = 1'b1;
			end
			// Both bytes go through WZ, then the pair or PC takes WZ
			IC_LXI, IC_JMP, IC_JCOND: begin
				case (step)
					4'd0: exec_word = mar_word(`REG_PC);
					4'd1: exec_word = bit_word(`CW_MEM_OE) | wr_word(`REG_Z);
					4'd2: exec_word = ext_word(`REG_PC, `REG_INC);
					4'd3: exec_word = mar_word(`REG_PC);
					4'd4: exec_word = bit_word(`CW_MEM_OE) | wr_word(`REG_W);
					default: begin
						if (iclass == IC_LXI && step == 4'd5) begin
							exec_word = wr_word(pair_hi_sel) | rd_word(`REG_WZ);
						end else if (iclass == IC_LXI) begin
							exec_word = ext_word(`REG_PC, `REG_INC);
							last = 1'b1;
						end else begin
							exec_word = wr_word(`REG_PC) | rd_word(`REG_WZ);
							last = 1'b1;
						end
					end
				endcase
				// Skip the address bytes
				if (iclass == IC_JCOND && !cond_met) begin
					exec_word = ext_word(`REG_PC, `REG_INC2);
					last = 1'b1;
				end
			end
			default: begin
				last = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_consts.svh"

module instr_decoder
	import ctrl_pkg::*;
(
	input wire opcode_t opcode,
	input wire flags_t flags,
	output instr_class_t iclass,
	output reg_sel_t dst_sel,
	output reg_sel_t src_sel,
	output logic dst_is_acc,
	output logic src_is_acc,
	output reg_sel_t pair_hi_sel,
	output alu_op_t alu_op,
	output reg_ext_t ext_dir,
	output logic cond_met
);

	// Order matters: HLT sits inside the MOV space, M forms before general forms
	always_comb begin
		casez (opcode)
			8'o166: iclass = IC_HLT;
			8'o1?6: iclass = IC_MOV_RM;
			8'o16?: iclass = IC_MOV_MR;
			8'o1??: iclass = IC_MOV_RR;
			8'o066: iclass = IC_MVI_M;
			8'o0?6: iclass = IC_MVI_R;
			8'o064, 8'o065: iclass = IC_INR_M;
			8'o0?4, 8'o0?5: iclass = IC_INR_R;
			8'o0?3: iclass = IC_INX;
			8'o2?6: iclass = IC_ALU_M;
			8'o2??: iclass = IC_ALU_R;
			8'o0?7: iclass = IC_ALU_A;
			8'o001, 8'o021, 8'o041, 8'o061: iclass = IC_LXI;
			8'o303: iclass = IC_JMP;
			8'o3?2: iclass = IC_JCOND;
			default: iclass = IC_NOP;
		endcase
	end

	// 8-bit halves named by the opcode fields
	assign dst_sel = {2'b00, opcode[5:3]};
	assign src_sel = {2'b00, opcode[2:0]};
	assign dst_is_acc = (opcode[5:3] == 3'b111);
	assign src_is_acc = (opcode[2:0] == 3'b111);

	// Pair code 3 means SP here, not PC
	always_comb begin
		if (opcode[5:4] == 2'b11) begin
			pair_hi_sel = `REG_SP;
		end else begin
			pair_hi_sel = {2'b10, opcode[5:4], 1'b0};
		end
	end

	always_comb begin
		if (opcode[7:6] == 2'b10) begin
			alu_op = `ALU_OP_SET0 | {2'b00, opcode[5:3]};
		end else if (opcode[7:6] == 2'b00 && opcode[2:0] == 3'b111) begin
			alu_op = `ALU_OP_SET1 | {2'b00, opcode[5:3]};
		end else if (opcode[0]) begin
			alu_op = `ALU_OP_DEC;
		end else begin
			alu_op = `ALU_OP_INC;
		end
	end

	// INX when bit 3 is clear, DCX when set
	assign ext_dir = opcode[3] ? `REG_DEC : `REG_INC;

	assign cond_met = (flags[opcode[5:4]] == opcode[3]);

endmodule

`default_nettype wire

// ==== rtl/stage_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_consts.svh"

module stage_sequencer
	import ctrl_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire instr_class_t iclass,
	input wire ctrl_word_t exec_word,
	input wire last,
	output stage_t stage,
	output ctrl_word_t ctrl_word
);

	seq_state_t state;

	// Stage steps on the falling edge so the word is settled by the rising edge
	always_ff @(negedge clk) begin
		if (!rst) begin
			stage <= '0;
			state <= SEQ_RUN;
		end else if (state == SEQ_RUN) begin
			if (stage == `FETCH_STAGES && iclass == IC_HLT) begin
				state <= SEQ_HALT;
			end else if (stage >= `FETCH_STAGES && last) begin
				stage <= '0;
			end else begin
				stage <= stage + 1'b1;
			end
		end
	end

	// Halted: stage stays at 3, the HLT word keeps coming out
	always_comb begin
		ctrl_word = '0;
		case (stage)
			4'd0: begin
				// PC to MAR
				ctrl_word[`CW_REG_RD_SEL_HI:`CW_REG_RD_SEL_LO] = `REG_PC;
				ctrl_word[`CW_REG_OE] = 1'b1;
				ctrl_word[`CW_MEM_MAR_WE] = 1'b1;
			end
			4'd1: begin
				// Opcode into IR
				ctrl_word[`CW_MEM_OE] = 1'b1;
				ctrl_word[`CW_IR_WE] = 1'b1;
			end
			4'd2: begin
				ctrl_word[`CW_REG_WR_SEL_HI:`CW_REG_WR_SEL_LO] = `REG_PC;
				ctrl_word[`CW_REG_EXT_HI:`CW_REG_EXT_LO] = `REG_INC;
			end
			default: begin
				ctrl_word = exec_word;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+rtl
+incdir+testbench
rtl/ctrl_pkg.sv
rtl/instr_decoder.sv
rtl/exec_microcode.sv
rtl/stage_sequencer.sv
rtl/controller.sv
testbench/controller_tb.sv

// ==== testbench/ctrl_expect.svh ====
`ifndef CTRL_EXPECT_SVH
`define CTRL_EXPECT_SVH

// Expected sequence of the current instruction, filled by build_expected
ctrl_word_t exp_seq [0:7];
int exp_len;

function automatic ctrl_word_t field_at(input int lo, input int val);
	return ctrl_word_t'(val) << lo;
endfunction

function automatic ctrl_word_t read_reg(input int sel);
	return field_at(`CW_REG_OE, 1) | field_at(`CW_REG_RD_SEL_LO, sel);
endfunction

function automatic ctrl_word_t write_reg(input int sel);
	return field_at(`CW_REG_WE, 1) | field_at(`CW_REG_WR_SEL_LO, sel);
endfunction

// In-place increment or decrement of a register
function automatic ctrl_word_t step_reg(input int sel, input int ext);
	return field_at(`CW_REG_WR_SEL_LO, sel) | field_at(`CW_REG_EXT_LO, ext);
endfunction

function automatic ctrl_word_t load_mar(input int sel);
	return read_reg(sel) | field_at(`CW_MEM_MAR_WE, 1);
endfunction

function automatic ctrl_word_t alu_run(input int op);
	return field_at(`CW_ALU_CS, 1) | field_at(`CW_ALU_OP_LO, op);
endfunction

function automatic ctrl_word_t fetch_word(input int st);
	if (st == 0) begin
		return load_mar(`REG_PC);
	end else if (st == 1) begin
		return field_at(`CW_MEM_OE, 1) | field_at(`CW_IR_WE, 1);
	end
	return step_reg(`REG_PC, `REG_INC);
endfunction

function automatic instr_class_t classify(input opcode_t op);
	logic [2:0] d;
	logic [2:0] s;
	d = op[5:3];
	s = op[2:0];
	if (op == 8'h76) begin
		return IC_HLT;
	end
	case (op[7:6])
		2'd1: return (s == 3'd6) ? IC_MOV_RM : ((d == 3'd6) ? IC_MOV_MR : IC_MOV_RR);
		2'd2: return (s == 3'd6) ? IC_ALU_M : IC_ALU_R;
		2'd3: begin
			if (op == 8'hc3) begin
				return IC_JMP;
			end
			return (s == 3'd2) ? IC_JCOND : IC_NOP;
		end
		default: begin
			case (s)
				3'd1: return d[0] ? IC_NOP : IC_LXI;
				3'd3: return IC_INX;
				3'd4, 3'd5: return (d == 3'd6) ? IC_INR_M : IC_INR_R;
				3'd6: return (d == 3'd6) ? IC_MVI_M : IC_MVI_R;
				3'd7: return IC_ALU_A;
				default: return IC_NOP;
			endcase
		end
	endcase
endfunction

// Pair 3 is SP for LXI and INX/DCX
function automatic int pair_code(input opcode_t op);
	case (op[5:4])
		2'd0: return `REG_BC;
		2'd1: return `REG_DE;
		2'd2: return `REG_HL;
		default: return `REG_SP;
	endcase
endfunction

task automatic build_expected(input opcode_t op, input flags_t f);
	instr_class_t ic;
	int d;
	int s;
	int i;
	int incdec;
	ctrl_word_t src;
	ctrl_word_t dst;
	ctrl_word_t mem_rd;
	ic = classify(op);
	d = op[5:3];
	s = op[2:0];
	incdec = op[0] ? `ALU_OP_DEC : `ALU_OP_INC;
	// Accumulator is reached through the ALU
	src = (s == 7) ? field_at(`CW_ALU_OE, 1) : read_reg(s);
	dst = (d == 7) ? field_at(`CW_ALU_A_WE, 1) : write_reg(d);
	mem_rd = field_at(`CW_MEM_OE, 1);
	for (i = 0; i < 8; i++) begin
		exp_seq[i] = '0;
	end
	exp_len = 1;
	case (ic)
		IC_HLT: exp_seq[0] = field_at(`CW_HLT, 1);
		IC_MOV_RR: exp_seq[0] = src | dst;
		IC_MOV_RM, IC_MOV_MR: begin
			exp_len = 2;
			exp_seq[0] = load_mar(`REG_HL);
			exp_seq[1] = (ic == IC_MOV_RM) ? (mem_rd | dst) : (src | field_at(`CW_MEM_WE, 1));
		end
		IC_MVI_R: begin
			exp_len = 3;
			exp_seq[0] = load_mar(`REG_PC);
			exp_seq[1] = mem_rd | dst;
			exp_seq[2] = step_reg(`REG_PC, `REG_INC);
		end
		IC_MVI_M: begin
			exp_len = 5;
			exp_seq[0] = load_mar(`REG_PC);
			exp_seq[1] = mem_rd | write_reg(`REG_W);
			exp_seq[2] = load_mar(`REG_HL);
			exp_seq[3] = read_reg(`REG_W) | field_at(`CW_MEM_WE, 1);
			exp_seq[4] = step_reg(`REG_PC, `REG_INC);
		end
		IC_INR_R: begin
			if (d == 7) begin
				exp_seq[0] = alu_run(incdec);
			end else begin
				exp_len = 3;
				exp_seq[0] = read_reg(d) | field_at(`CW_ALU_A_STORE, 1)
					| field_at(`CW_ALU_A_WE, 1);
				exp_seq[1] = alu_run(incdec);
				exp_seq[2] = field_at(`CW_ALU_OE, 1) | field_at(`CW_ALU_A_RESTORE, 1)
					| write_reg(d);
			end
		end
		IC_INR_M: begin
			exp_len = 4;
			exp_seq[0] = load_mar(`REG_HL);
			exp_seq[1] = mem_rd | field_at(`CW_ALU_A_STORE, 1) | field_at(`CW_ALU_A_WE, 1);
			exp_seq[2] = alu_run(incdec);
			exp_seq[3] = field_at(`CW_ALU_OE, 1) | field_at(`CW_ALU_A_RESTORE, 1)
				| field_at(`CW_MEM_WE, 1);
		end
		IC_INX: exp_seq[0] = step_reg(pair_code(op), op[3] ? `REG_DEC : `REG_INC);
		IC_ALU_R: begin
			exp_seq[0] = src | field_at(`CW_ALU_TMP_WE, 1);
			if (s == 7) begin
				exp_seq[0] = exp_seq[0] | alu_run(d);
			end else begin
				exp_len = 2;
				exp_seq[1] = alu_run(d);
			end
		end
		IC_ALU_M: begin
			exp_len = 3;
			exp_seq[0] = load_mar(`REG_HL);
			exp_seq[1] = mem_rd | field_at(`CW_ALU_TMP_WE, 1);
			exp_seq[2] = alu_run(d);
		end
		IC_ALU_A: exp_seq[0] = alu_run(8 + d);
		IC_LXI, IC_JMP, IC_JCOND: begin
			exp_len = (ic == IC_LXI) ? 7 : 6;
			exp_seq[0] = load_mar(`REG_PC);
			exp_seq[1] = mem_rd | write_reg(`REG_Z);
			exp_seq[2] = step_reg(`REG_PC, `REG_INC);
			exp_seq[3] = load_mar(`REG_PC);
			exp_seq[4] = mem_rd | write_reg(`REG_W);
			exp_seq[5] = write_reg((ic == IC_LXI) ? pair_code(op) : `REG_PC) | read_reg(`REG_WZ);
			exp_seq[6] = step_reg(`REG_PC, `REG_INC);
			// Not taken: skip both address bytes
			if (ic == IC_JCOND && f[op[5:4]] != op[3]) begin
				exp_len = 1;
				exp_seq[0] = step_reg(`REG_PC, `REG_INC2);
			end
		end
		default: exp_len = 1;
	endcase
endtask

`endif

// ==== testbench/controller_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_consts.svh"

module controller_tb
	import ctrl_pkg::*;
();

	logic clk;
	logic rst;
	opcode_t opcode;
	flags_t flags;
	ctrl_word_t ctrl_word;
	logic [31:0] lfsr;

	`include "ctrl_expect.svh"

	controller dut (
		.clk(clk),
		.rst(rst),
		.opcode(opcode),
		.flags(flags),
		.ctrl_word(ctrl_word)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			stop_with_error($sformatf("mismatch %s: expected %h, actual %h",
				test, expected, actual));
		end
	endtask

	// Returns on the rising edge where the stage-0 word shows
	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b1;
	endtask

	task automatic start_instr(input string name, input opcode_t op, input flags_t f);
		int st;
		check_value($sformatf("%s op %h fetch 0", name, op), fetch_word(0), ctrl_word);
		opcode <= op;
		flags <= f;
		for (st = 1; st < 3; st++) begin
			@(posedge clk);
			check_value($sformatf("%s op %h fetch %0d", name, op, st), fetch_word(st), ctrl_word);
		end
	endtask

	task automatic run_instr(input string name, input opcode_t op, input flags_t f);
		int n;
		start_instr(name, op, f);
		build_expected(op, f);
		n = 0;
		@(posedge clk);
		while (n < exp_len || ctrl_word !== fetch_word(0)) begin
			if (n >= 16) begin
				stop_with_error($sformatf("timeout: %s op %h never returned to fetch", name, op));
			end
			if (n < exp_len) begin
				check_value($sformatf("%s op %h step %0d", name, op, n), exp_seq[n], ctrl_word);
			end
			n++;
			@(posedge clk);
		end
		check_value($sformatf("%s op %h stage count", name, op), exp_len, n);
	endtask

	task automatic reset_and_fetch();
		apply_reset();
		run_instr("nop", 8'h00, 8'h00);
		run_instr("nop", 8'h00, 8'hff);
	endtask

	task automatic register_moves();
		int i;
		logic [2:0] d;
		logic [2:0] s;
		for (i = 0; i < 12; i++) begin
			d = 3'(rand_bits(3));
			s = 3'(rand_bits(3));
			// Field 6 is M so A is used instead
			if (d == 3'd6) d = 3'd7;
			if (s == 3'd6) s = 3'd7;
			run_instr("mov_rr", {2'b01, d, s}, flags_t'(rand_bits(8)));
			run_instr("mvi_r", {2'b00, d, 3'b110}, flags_t'(rand_bits(8)));
		end
		run_instr("mov_rr", 8'h78, 8'h00);
		run_instr("mov_rr", 8'h47, 8'h00);
	endtask

	task automatic memory_via_hl();
		int i;
		for (i = 0; i < 8; i++) begin
			if (i != 6) begin
				run_instr("mov_rm", {2'b01, 3'(i), 3'b110}, flags_t'(rand_bits(8)));
				run_instr("mov_mr", {2'b01, 3'b110, 3'(i)}, flags_t'(rand_bits(8)));
			end
		end
		run_instr("mvi_m", 8'h36, 8'h00);
		run_instr("inr_m", 8'h34, 8'h00);
		run_instr("dcr_m", 8'h35, 8'h00);
	endtask

	task automatic alu_operations();
		int i;
		logic [2:0] r;
		for (i = 0; i < 8; i++) begin
			r = 3'(rand_bits(3));
			if (r == 3'd6) r = 3'd7;
			run_instr("alu_r", {2'b10, 3'(i), r}, flags_t'(rand_bits(8)));
			run_instr("alu_m", {2'b10, 3'(i), 3'b110}, flags_t'(rand_bits(8)));
			run_instr("alu_a", {2'b00, 3'(i), 3'b111}, flags_t'(rand_bits(8)));
			if (i != 6) begin
				run_instr("inr_r", {2'b00, 3'(i), 3'b100}, 8'h00);
				run_instr("dcr_r", {2'b00, 3'(i), 3'b101}, 8'h00);
			end
			run_instr("inx_dcx", {2'b00, 3'(i), 3'b011}, 8'h00);
		end
		run_instr("alu_r", 8'h87, 8'h00);
	endtask

	task automatic loads_and_jumps();
		int i;
		flags_t f;
		for (i = 0; i < 4; i++) begin
			run_instr("lxi", {2'b00, 2'(i), 4'b0001}, flags_t'(rand_bits(8)));
		end
		run_instr("jmp", 8'hc3, flags_t'(rand_bits(8)));
		// Each condition once as drawn and once with its flag flipped
		for (i = 0; i < 8; i++) begin
			f = flags_t'(rand_bits(8));
			run_instr("jcond", {2'b11, 3'(i), 3'b010}, f);
			f[i / 2] = ~f[i / 2];
			run_instr("jcond", {2'b11, 3'(i), 3'b010}, f);
		end
	endtask

	task automatic halt_and_unsupported();
		opcode_t odd_ops [0:8];
		int i;
		odd_ops = '{8'hcd, 8'hc9, 8'hc5, 8'hd1, 8'h32, 8'h0a, 8'h09, 8'hd3, 8'hc4};
		for (i = 0; i < 9; i++) begin
			run_instr("unsupported", odd_ops[i], flags_t'(rand_bits(8)));
		end
		start_instr("hlt", 8'h76, flags_t'(rand_bits(8)));
		@(posedge clk);
		// Longer than one full pass of the stage counter
		for (i = 0; i < 17; i++) begin
			check_value($sformatf("hlt hold cycle %0d", i), field_at(`CW_HLT, 1), ctrl_word);
			@(posedge clk);
		end
		apply_reset();
		run_instr("after hlt", 8'h00, 8'h00);
	endtask

	initial begin
		rst = 1'b0;
		opcode = 8'h00;
		flags = 8'h00;
		lfsr = 32'h4a5270dc;
		reset_and_fetch();
		register_moves();
		memory_via_hl();
		alu_operations();
		loads_and_jumps();
		halt_and_unsupported();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire
